/* Bender.yml */
package:
  name: display_engine

sources:
  - include_dirs:
      - hw
    files:
      - hw/anticPkg.sv
      - hw/gtiaPkg.sv
      - hw/dlistDecode.sv
      - hw/dlistExecute.sv
      - hw/rowColorResult.sv
      - hw/displayEngine.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/displayEngineTb.sv

/* hw/anticPkg.sv */
/* ANTIC side types: the display-list instruction byte, a decoded
   command and the row descriptor passed on to the colour stage */
`include "display_defs.svh"

package anticPkg;

  // Blank-line instruction, mode field is zero
  typedef struct packed {
    logic       dli;
    logic [2:0] lineCount; // Lines minus one
    logic [3:0] mode;
  } blankView_t;

  typedef struct packed {
    logic       dli;
    logic       lms;    // Also marks JVB when mode is 1
    logic       vscrol;
    logic       hscrol;
    logic [3:0] mode;
  } modeView_t;

  // One instruction byte, read either way depending on the mode
  typedef union packed {
    blankView_t blankView;
    modeView_t  modeView;
  } dlInstr_u;

  typedef struct packed {
    dlInstr_u              instr;
    logic [`DL_ADDR_W-1:0] operand; // LMS address or jump target
  } dlCmd_t;

  typedef enum logic [1:0] {
    rowBlank,
    rowMode,
    rowFrameEnd
  } rowKind_e;

  typedef struct packed {
    rowKind_e              kind;
    logic [3:0]            mode;
    logic [3:0]            lines;
    logic [`DL_ADDR_W-1:0] scanAddr;
    logic [5:0]            bytes;
    logic                  dli;
  } rowDesc_t;

endpackage

/* hw/displayEngine.sv */
/* Display-list engine top level. Chains decode, execute and the
   colour stage; display-list bytes in, coloured rows out */
module displayEngine (
  input  logic                 USER_CLK,
  input  logic                 rst,
  input  logic [7:0]           dlByte,
  input  logic                 dlValid,
  output logic                 dlReady,
  input  gtiaPkg::colorWrite_t colorWr,
  input  logic                 colorWrEn,
  output gtiaPkg::rowResult_t  row,
  output logic                 rowValid,
  input  logic                 rowReady
);

  anticPkg::dlCmd_t   cmd;
  logic               cmdValid;
  logic               cmdReady;
  anticPkg::rowDesc_t desc;
  logic               descValid;
  logic               descReady;

  dlistDecode u_decode (
    .USER_CLK (USER_CLK),
    .rst      (rst),
    .dlByte   (dlByte),
    .dlValid  (dlValid),
    .dlReady  (dlReady),
    .cmd      (cmd),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady)
  );

  dlistExecute u_execute (
    .USER_CLK  (USER_CLK),
    .rst       (rst),
    .cmd       (cmd),
    .cmdValid  (cmdValid),
    .cmdReady  (cmdReady),
    .desc      (desc),
    .descValid (descValid),
    .descReady (descReady)
  );

  rowColorResult u_result (
    .USER_CLK  (USER_CLK),
    .rst       (rst),
    .colorWr   (colorWr),
    .colorWrEn (colorWrEn),
    .desc      (desc),
    .descValid (descValid),
    .descReady (descReady),
    .row       (row),
    .rowValid  (rowValid),
    .rowReady  (rowReady)
  );

endmodule

/* hw/display_defs.svh */
/* Sizes and mode-table constants for the display-list engine.
   Included by the packages and by any stage that needs them */
`ifndef DISPLAY_DEFS_SVH
`define DISPLAY_DEFS_SVH

// Display-list and screen address width
`define DL_ADDR_W 16

`define COLOR_W 8

// Scan-line counter, wraps at the frame height
`define LINE_CNT_W 8
`define FRAME_LINES 9'd240

// Bytes per row for the narrow and wide modes
`define MODE_BYTES_NARROW 6'd10
`define MODE_BYTES_WIDE 6'd40

// Special instruction modes
`define MODE_BLANK 4'd0
`define MODE_JUMP 4'd1

`endif

/* hw/dlistDecode.sv */
/* Collects display-list bytes into complete commands. LMS and jump
   opcodes pick up two operand bytes, low byte first */
`include "display_defs.svh"

module dlistDecode (
  input  logic             USER_CLK,
  input  logic             rst,
  input  logic [7:0]       dlByte,
  input  logic             dlValid,
  output logic             dlReady,
  output anticPkg::dlCmd_t cmd,
  output logic             cmdValid,
  input  logic             cmdReady
);

  typedef enum logic [1:0] {
    stOpcode,
    stLow,
    stHigh
  } decState_e;

  decState_e          state;
  anticPkg::dlInstr_u byteView;  // Incoming byte seen as an opcode
  anticPkg::dlInstr_u instrReg;  // Opcode waiting for its operand
  logic [7:0]         lowReg;
  logic               needOperand;
  logic               byteTaken;

  assign byteView  = dlByte;
  assign dlReady   = !cmdValid || cmdReady;
  assign byteTaken = dlValid && dlReady;

  // Blank opcodes reuse bit 6 as part of the line count
  always_comb begin
    if (byteView.modeView.mode == `MODE_JUMP)
      needOperand = 1'b1;
    else if (byteView.modeView.mode == `MODE_BLANK)
      needOperand = 1'b0;
    else
      needOperand = byteView.modeView.lms;
  end

  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      state    <= stOpcode;
      cmdValid <= 1'b0;
    end else begin
      if (cmdValid && cmdReady)
        cmdValid <= 1'b0;
      if (byteTaken) begin
        case (state)
          stOpcode: begin
            if (needOperand)
              state <= stLow;
            else
              cmdValid <= 1'b1; // Single-byte command
          end
          stLow: state <= stHigh;
          stHigh: begin
            state    <= stOpcode;
            cmdValid <= 1'b1;
          end
          default: state <= stOpcode;
        endcase
      end
    end
  end

  always_ff @(posedge USER_CLK) begin
    if (byteTaken) begin
      case (state)
        stOpcode: begin
          instrReg <= byteView;
          if (!needOperand) begin
            cmd.instr   <= byteView;
            cmd.operand <= '0;
          end
        end
        stLow: lowReg <= dlByte;
        stHigh: begin
          cmd.instr   <= instrReg;
          cmd.operand <= {dlByte, lowReg};
        end
        default: ;
      endcase
    end
  end

endmodule

/* hw/dlistExecute.sv */
/* Execute stage. Keeps the memory scan counter and expands each command
   into a row descriptor; plain jumps are absorbed here */
`include "display_defs.svh"

module dlistExecute (
  input  logic               USER_CLK,
  input  logic               rst,
  input  anticPkg::dlCmd_t   cmd,
  input  logic               cmdValid,
  output logic               cmdReady,
  output anticPkg::rowDesc_t desc,
  output logic               descValid,
  input  logic               descReady
);

  anticPkg::dlInstr_u    instr;
  logic [`DL_ADDR_W-1:0] scanCnt;
  logic [`DL_ADDR_W-1:0] baseAddr;
  logic [3:0]            rowLines;
  logic [5:0]            rowBytes;
  logic                  cmdTaken;
  logic                  isBlank;
  logic                  isJump;
  logic                  emitRow;

  assign instr    = cmd.instr;
  assign cmdReady = !descValid || descReady;
  assign cmdTaken = cmdValid && cmdReady;
  assign isBlank  = instr.blankView.mode == `MODE_BLANK;
  assign isJump   = instr.modeView.mode == `MODE_JUMP;
  assign emitRow  = !isJump || instr.modeView.lms; // JMP gives no row

  // LMS reloads the scan counter before the row is built
  assign baseAddr = (!isBlank && !isJump && instr.modeView.lms) ? cmd.operand : scanCnt;

  // Mode table
  always_comb begin
    case (instr.modeView.mode)
      4'd2, 4'd3, 4'd4, 4'd5: begin
        rowLines = 4'd8;
        rowBytes = `MODE_BYTES_WIDE;
      end
      4'd6, 4'd7, 4'd8, 4'd9: begin
        rowLines = 4'd8;
        rowBytes = `MODE_BYTES_NARROW;
      end
      4'd10, 4'd11, 4'd12: begin
        rowLines = 4'd4;
        rowBytes = `MODE_BYTES_WIDE;
      end
      4'd13: begin
        rowLines = 4'd2;
        rowBytes = `MODE_BYTES_WIDE;
      end
      4'd14, 4'd15: begin
        rowLines = 4'd1;
        rowBytes = `MODE_BYTES_WIDE;
      end
      default: begin // Blank and jump
        rowLines = 4'd0;
        rowBytes = 6'd0;
      end
    endcase
  end

  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      descValid <= 1'b0;
      scanCnt   <= '0;
    end else begin
      if (descValid && descReady)
        descValid <= 1'b0;
      if (cmdTaken && emitRow)
        descValid <= 1'b1;
      if (cmdTaken && !isBlank && !isJump)
        scanCnt <= baseAddr + {{(`DL_ADDR_W-6){1'b0}}, rowBytes};
    end
  end

  always_ff @(posedge USER_CLK) begin
    if (cmdTaken) begin
      desc.mode  <= instr.modeView.mode;
      desc.dli   <= instr.modeView.dli;
      desc.bytes <= rowBytes;
      if (isBlank) begin
        desc.kind     <= anticPkg::rowBlank;
        desc.lines    <= {1'b0, instr.blankView.lineCount} + 4'd1;
        desc.scanAddr <= scanCnt;
      end else if (isJump) begin
        desc.kind     <= anticPkg::rowFrameEnd;
        desc.lines    <= 4'd0;
        desc.scanAddr <= cmd.operand; // JVB target, carried only
      end else begin
        desc.kind     <= anticPkg::rowMode;
        desc.lines    <= rowLines;
        desc.scanAddr <= baseAddr;
      end
    end
  end

endmodule

/* hw/gtiaPkg.sv */
/* GTIA side types: colour register selection, register writes and
   the coloured row record at the engine output */
`include "display_defs.svh"

package gtiaPkg;

  typedef enum logic [2:0] {
    COLPF0,
    COLPF1,
    COLPF2,
    COLPF3,
    COLBK
  } colorReg_e;

  // Register write from the host side
  typedef struct packed {
    colorReg_e           regSel;
    logic [`COLOR_W-1:0] value;
  } colorWrite_t;

  typedef struct packed {
    anticPkg::rowDesc_t     desc;
    logic [`LINE_CNT_W-1:0] firstLine; // Scan line the row starts on
    logic [`COLOR_W-1:0]    color;
  } rowResult_t;

endpackage

/* hw/rowColorResult.sv */
/* Result stage. Holds the colour registers and the running scan-line
   count, and gives every row its colour and first line */
`include "display_defs.svh"

module rowColorResult (
  input  logic                 USER_CLK,
  input  logic                 rst,
  input  gtiaPkg::colorWrite_t colorWr,
  input  logic                 colorWrEn,
  input  anticPkg::rowDesc_t   desc,
  input  logic                 descValid,
  output logic                 descReady,
  output gtiaPkg::rowResult_t  row,
  output logic                 rowValid,
  input  logic                 rowReady
);

  logic [`COLOR_W-1:0]    colorRegs [5];
  logic [`LINE_CNT_W-1:0] lineCnt;
  logic [`LINE_CNT_W:0]   lineSum;
  logic [`LINE_CNT_W:0]   lineWrap;
  gtiaPkg::colorReg_e     colorSel;
  logic                   descTaken;

  assign descReady = !rowValid || rowReady;
  assign descTaken = descValid && descReady;
  assign lineSum   = {1'b0, lineCnt} + {{(`LINE_CNT_W-3){1'b0}}, desc.lines};
  assign lineWrap  = lineSum - `FRAME_LINES;

  // Playfield register by mode, background otherwise
  always_comb begin
    if (desc.kind != anticPkg::rowMode)
      colorSel = gtiaPkg::COLBK;
    else if (desc.mode inside {[4'd2:4'd3]})
      colorSel = gtiaPkg::COLPF2;
    else if (desc.mode inside {[4'd4:4'd7]})
      colorSel = gtiaPkg::COLPF0;
    else
      colorSel = gtiaPkg::COLPF1;
  end

  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      rowValid <= 1'b0;
      lineCnt  <= '0;
      for (int i = 0; i < 5; i++)
        colorRegs[i] <= '0;
    end else begin
      if (colorWrEn)
        colorRegs[colorWr.regSel] <= colorWr.value;
      if (rowValid && rowReady)
        rowValid <= 1'b0;
      if (descTaken) begin
        rowValid <= 1'b1;
        if (desc.kind == anticPkg::rowFrameEnd)
          lineCnt <= '0; // New frame
        else if (lineSum >= `FRAME_LINES)
          lineCnt <= lineWrap[`LINE_CNT_W-1:0];
        else
          lineCnt <= lineSum[`LINE_CNT_W-1:0];
      end
    end
  end

  always_ff @(posedge USER_CLK) begin
    if (descTaken) begin
      row.desc      <= desc;
      row.firstLine <= lineCnt;
      row.color     <= colorRegs[colorSel];
    end
  end

endmodule

/* sim/displayEngineTb.sv */
/* Testbench for the display-list engine. Streams a display-list table through
   the DUT with random stalls on both sides and checks every coloured row */
module displayEngineTb;

  localparam anticPkg::rowKind_e kindBlank = anticPkg::rowBlank;
  localparam anticPkg::rowKind_e kindMode  = anticPkg::rowMode;
  localparam anticPkg::rowKind_e kindEnd   = anticPkg::rowFrameEnd;

  // One feeder step holds a display-list byte or a colour write
  typedef struct packed {
    logic                 isColor;
    gtiaPkg::colorWrite_t wr;
    logic [7:0]           dlb;
    int                   rowsBefore; // Rows out before the write may happen
  } feedStep_t;

  logic                 USER_CLK;
  logic                 rst;
  logic [7:0]           dlByte;
  logic                 dlValid;
  logic                 dlReady;
  gtiaPkg::colorWrite_t colorWr;
  logic                 colorWrEn;
  gtiaPkg::rowResult_t  row;
  logic                 rowValid;
  logic                 rowReady;

  feedStep_t           steps[$];
  gtiaPkg::rowResult_t expRows[$];
  string               expNames[$];
  int                  byteCount = 0;
  int                  rowsSeen = 0;
  int                  cycleCount = 0;
  int                  cycleLimit = 0;
  int                  valueErrors = 0;
  int                  extraErrors = 0;
  int                  timeoutErrors = 0;
  logic                tableBuilt = 1'b0;

  displayEngine u_dut (
    .USER_CLK  (USER_CLK),
    .rst       (rst),
    .dlByte    (dlByte),
    .dlValid   (dlValid),
    .dlReady   (dlReady),
    .colorWr   (colorWr),
    .colorWrEn (colorWrEn),
    .row       (row),
    .rowValid  (rowValid),
    .rowReady  (rowReady)
  );

  initial begin
    USER_CLK = 1'b0;
    forever #10 USER_CLK = ~USER_CLK;
  end

  always @(posedge USER_CLK) cycleCount++;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic addInstr(input logic [7:0] op);
    feedStep_t s;
    s.isColor    = 1'b0;
    s.wr         = '0;
    s.dlb        = op;
    s.rowsBefore = 0;
    steps.push_back(s);
    byteCount++;
  endtask

  // Opcode then its address with the low byte first
  task automatic addWithOperand(input logic [7:0] op, input logic [15:0] operand);
    addInstr(op);
    addInstr(operand[7:0]);
    addInstr(operand[15:8]);
  endtask

  task automatic addColor(input gtiaPkg::colorReg_e sel, input logic [7:0] value);
    feedStep_t s;
    s.isColor      = 1'b1;
    s.wr.regSel    = sel;
    s.wr.value     = value;
    s.dlb          = '0;
    s.rowsBefore   = expRows.size();
    steps.push_back(s);
  endtask

  task automatic expectRow(input string name, input anticPkg::rowKind_e kind,
                           input logic [3:0] mode, input logic [3:0] lines,
                           input logic [15:0] addr, input logic [5:0] nBytes,
                           input logic dli, input logic [7:0] firstLine,
                           input logic [7:0] color);
    gtiaPkg::rowResult_t r;
    r.desc.kind     = kind;
    r.desc.mode     = mode;
    r.desc.lines    = lines;
    r.desc.scanAddr = addr;
    r.desc.bytes    = nBytes;
    r.desc.dli      = dli;
    r.firstLine     = firstLine;
    r.color         = color;
    expRows.push_back(r);
    expNames.push_back(name);
  endtask

  // Single-byte instruction and the row it should produce
  task automatic addRowInstr(input logic [7:0] op, input string name,
                             input anticPkg::rowKind_e kind, input logic [3:0] mode,
                             input logic [3:0] lines, input logic [15:0] addr,
                             input logic [5:0] nBytes, input logic dli,
                             input logic [7:0] firstLine, input logic [7:0] color);
    addInstr(op);
    expectRow(name, kind, mode, lines, addr, nBytes, dli, firstLine, color);
  endtask

  task automatic checkRow(input string name, input gtiaPkg::rowResult_t expRow,
                          input gtiaPkg::rowResult_t actRow);
    if (actRow !== expRow) begin
      valueErrors++;
      $display("FAILED %s: expected %h, actual %h", name, expRow, actRow);
    end
  endtask

  task automatic checkDesc(input string name, input anticPkg::rowDesc_t expDesc,
                           input anticPkg::rowDesc_t actDesc);
    if (actDesc !== expDesc) begin
      valueErrors++;
      $display("FAILED %s: expected %h, actual %h", name, expDesc, actDesc);
    end
  endtask

  task automatic buildTable;
    addColor(gtiaPkg::COLBK, 'h94);
    addColor(gtiaPkg::COLPF0, 'h28);
    addColor(gtiaPkg::COLPF1, 'hCA);
    addColor(gtiaPkg::COLPF2, 'h46);
    addColor(gtiaPkg::COLPF3, 'h0E);
    // Frame 1 opens with blank rows of 1 to 8 lines
    addRowInstr('h00, "blank lc0", kindBlank, 0, 1, 'h0000, 0, 0, 0, 'h94);
    addRowInstr('h10, "blank lc1", kindBlank, 0, 2, 'h0000, 0, 0, 1, 'h94);
    addRowInstr('hA0, "blank lc2 dli", kindBlank, 0, 3, 'h0000, 0, 1, 3, 'h94);
    addRowInstr('h30, "blank lc3", kindBlank, 0, 4, 'h0000, 0, 0, 6, 'h94);
    addRowInstr('h40, "blank lc4", kindBlank, 0, 5, 'h0000, 0, 0, 10, 'h94);
    addRowInstr('hD0, "blank lc5 dli", kindBlank, 0, 6, 'h0000, 0, 1, 15, 'h94);
    addRowInstr('h60, "blank lc6", kindBlank, 0, 7, 'h0000, 0, 0, 21, 'h94);
    addRowInstr('hF0, "blank lc7 dli", kindBlank, 0, 8, 'h0000, 0, 1, 28, 'h94);
    addWithOperand('h42, 'h1000);
    expectRow("lms mode2", kindMode, 2, 8, 'h1000, 40, 0, 36, 'h46);
    addRowInstr('h06, "mode6", kindMode, 6, 8, 'h1028, 10, 0, 44, 'h28);
    addRowInstr('h88, "mode8 dli", kindMode, 8, 8, 'h1032, 10, 1, 52, 'hCA);
    addRowInstr('h0A, "mode10", kindMode, 10, 4, 'h103C, 40, 0, 60, 'hCA);
    addRowInstr('h0D, "mode13", kindMode, 13, 2, 'h1064, 40, 0, 64, 'hCA);
    addRowInstr('h8F, "mode15 dli", kindMode, 15, 1, 'h108C, 40, 1, 66, 'hCA);
    addRowInstr('h04, "mode4", kindMode, 4, 8, 'h10B4, 40, 0, 67, 'h28);
    addWithOperand('h01, 'h2345); // Plain JMP gives no row
    addRowInstr('h07, "mode7 after jmp", kindMode, 7, 8, 'h10DC, 10, 0, 75, 'h28);
    addRowInstr('h03, "mode3", kindMode, 3, 8, 'h10E6, 40, 0, 83, 'h46);
    addWithOperand('h41, 'h0600);
    expectRow("jvb frame 1", kindEnd, 1, 0, 'h0600, 0, 0, 91, 'h94);
    // New colours between frames
    addColor(gtiaPkg::COLBK, 'h72);
    addColor(gtiaPkg::COLPF0, 'h1A);
    addColor(gtiaPkg::COLPF1, 'h3C);
    addColor(gtiaPkg::COLPF2, 'h5E);
    addRowInstr('h70, "f2 blank lc7", kindBlank, 0, 8, 'h110E, 0, 0, 0, 'h72);
    addWithOperand('hCE, 'h2000);
    expectRow("lms mode14 dli", kindMode, 14, 1, 'h2000, 40, 1, 8, 'h3C);
    addRowInstr('h09, "mode9", kindMode, 9, 8, 'h2028, 10, 0, 9, 'h3C);
    addRowInstr('h05, "mode5", kindMode, 5, 8, 'h2032, 40, 0, 17, 'h1A);
    addRowInstr('h02, "mode2", kindMode, 2, 8, 'h205A, 40, 0, 25, 'h5E);
    addRowInstr('h0B, "mode11", kindMode, 11, 4, 'h2082, 40, 0, 33, 'h3C);
    addRowInstr('h8C, "mode12 dli", kindMode, 12, 4, 'h20AA, 40, 1, 37, 'h3C);
    addRowInstr('h80, "blank dli", kindBlank, 0, 1, 'h20D2, 0, 1, 41, 'h72);
    addWithOperand('hC1, 'h0600);
    expectRow("jvb frame 2 dli", kindEnd, 1, 0, 'h0600, 0, 1, 42, 'h72);
    addColor(gtiaPkg::COLBK, 'h0F);
    addRowInstr('h20, "f3 blank lc2", kindBlank, 0, 3, 'h20D2, 0, 0, 0, 'h0F);
  endtask

  // Bytes go out with random gaps; colour writes wait for an empty pipeline
  task automatic feedBytes;
    int          idx;
    logic [31:0] rng;
    logic        holding;
    idx     = 0;
    rng     = 32'd62476;
    holding = 1'b0;
    while (idx < steps.size()) begin
      @(negedge USER_CLK);
      colorWrEn = 1'b0;
      if (!holding) begin
        dlValid = 1'b0;
        rng = xorshift32(rng);
        if (steps[idx].isColor) begin
          if (rowsSeen >= steps[idx].rowsBefore) begin
            colorWr   = steps[idx].wr;
            colorWrEn = 1'b1;
            idx++;
          end
        end else if (rng[1:0] != 2'd0) begin
          dlByte  = steps[idx].dlb;
          dlValid = 1'b1;
        end
      end
      #2;
      if (dlValid && dlReady) begin
        idx++;
        holding = 1'b0;
      end else begin
        holding = dlValid;
      end
    end
    @(negedge USER_CLK);
    colorWrEn = 1'b0;
    dlValid   = 1'b0;
  endtask

  // Rows taken under random back-pressure and compared in table order
  task automatic popRows;
    logic [31:0] rng;
    rng = 32'd62476;
    while (rowsSeen < expRows.size()) begin
      @(negedge USER_CLK);
      rng = xorshift32(rng);
      rowReady = (rng[3:2] != 2'd0);
      #1;
      if (rowValid && rowReady) begin
        if (expRows[rowsSeen].desc.kind == kindEnd)
          checkDesc(expNames[rowsSeen], expRows[rowsSeen].desc, row.desc);
        else
          checkRow(expNames[rowsSeen], expRows[rowsSeen], row);
        rowsSeen++;
      end
    end
  endtask

  task automatic checkIdle;
    @(negedge USER_CLK);
    rowReady = 1'b1;
    repeat (20) begin
      #1;
      if (rowValid) begin
        extraErrors++;
        $display("Unexpected extra row after the last expected one, kind %0d",
                 row.desc.kind);
      end
      @(negedge USER_CLK);
    end
  endtask

  task automatic finishRun;
    $display("Errors: %0d wrong values, %0d extra rows, %0d timeouts",
             valueErrors, extraErrors, timeoutErrors);
    if (valueErrors + extraErrors + timeoutErrors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  endtask

  initial begin
    wait (tableBuilt);
    while (cycleCount < cycleLimit)
      @(posedge USER_CLK);
    timeoutErrors++;
    $display("Timeout after %0d cycles: %0d of %0d rows never arrived",
             cycleCount, expRows.size() - rowsSeen, expRows.size());
    finishRun();
  end

  initial begin
    rst       = 1'b1;
    dlByte    = '0;
    dlValid   = 1'b0;
    colorWr   = '0;
    colorWrEn = 1'b0;
    rowReady  = 1'b0;
    buildTable();
    cycleLimit = 8 * byteCount + 200;
    tableBuilt = 1'b1;
    repeat (5) @(posedge USER_CLK);
    @(negedge USER_CLK);
    rst = 1'b0;
    fork
      feedBytes();
      popRows();
    join
    checkIdle();
    finishRun();
  end

endmodule

/* tb.f */
+incdir+hw
hw/anticPkg.sv
hw/gtiaPkg.sv
hw/dlistDecode.sv
hw/dlistExecute.sv
hw/rowColorResult.sv
hw/displayEngine.sv
sim/displayEngineTb.sv
